//--- verilog/yuv_pkg.sv
//--------------------
// Shared widths, constants and types for the YUV 4:2:2 to RGB datapath
// RTL modules reach these by scoped names
//--------------------
package yuv_pkg;

localparam int ROW_PAIRS = 8;       // Pixel pairs per row
localparam int PAIR_IDX_W = $clog2(ROW_PAIRS);
localparam int IN_DEPTH = 4;        // Also the sender's starting credits
localparam int OUT_CREDIT_MAX = 8;
localparam int PIPE_LAT = 3;        // Producing step to rgb_valid

// Chroma interpolation taps
localparam int TAP_21 = 21;
localparam int TAP_52 = 52;
localparam int TAP_159 = 159;
localparam int FILT_ROUND = 128;

// Colour conversion in 16.16 fixed point
localparam int Y_OFFSET = 16;
localparam int C_OFFSET = 128;
localparam int K_Y = 76284;
localparam int K_RV = 104595;
localparam int K_GU = 25624;
localparam int K_GV = 53281;
localparam int K_BU = 132251;

typedef logic [7:0] byte_t;
typedef logic [23:0] rgb_t;          // Red in top byte, then green, blue
typedef logic signed [31:0] acc_t;
typedef logic [PAIR_IDX_W-1:0] pair_idx_t;
typedef logic [$clog2(IN_DEPTH)-1:0] fifo_ptr_t;
typedef logic [$clog2(IN_DEPTH+1)-1:0] fifo_cnt_t;
typedef logic [$clog2(OUT_CREDIT_MAX+1)-1:0] credit_t;

typedef enum logic [1:0] {FILL, RUN, FLUSH} seq_state_e;

// Saturate a signed integer to 0..255
function automatic byte_t clip_byte(input acc_t v);
	if (v < 0) return 8'd0;
	if (v > 255) return 8'd255;
	return v[7:0];
endfunction

endpackage

//--- verilog/pair_fifo.sv
//--------------------
// Input buffer for YUV pixel pairs
// Head is visible combinationally, each pop returns one credit
//--------------------
`timescale 1ns/1ps

module pair_fifo (
	input  logic CLOCK_50_I,
	input  logic resetn,
	input  logic in_valid,
	input  yuv_pkg::byte_t in_y_even,
	input  yuv_pkg::byte_t in_y_odd,
	input  yuv_pkg::byte_t in_u,
	input  yuv_pkg::byte_t in_v,
	input  logic pop,
	output logic fifo_empty,
	output yuv_pkg::byte_t head_y_even,
	output yuv_pkg::byte_t head_y_odd,
	output yuv_pkg::byte_t head_u,
	output yuv_pkg::byte_t head_v,
	output logic in_credit
);

yuv_pkg::byte_t mem_y_even [yuv_pkg::IN_DEPTH];
yuv_pkg::byte_t mem_y_odd [yuv_pkg::IN_DEPTH];
yuv_pkg::byte_t mem_u [yuv_pkg::IN_DEPTH];
yuv_pkg::byte_t mem_v [yuv_pkg::IN_DEPTH];
yuv_pkg::fifo_ptr_t wr_ptr, rd_ptr;
yuv_pkg::fifo_cnt_t count;

function automatic yuv_pkg::fifo_ptr_t next_ptr(input yuv_pkg::fifo_ptr_t p);
	return (p == yuv_pkg::fifo_ptr_t'(yuv_pkg::IN_DEPTH - 1)) ? '0 : p + 1'b1;
endfunction

always_ff @(posedge CLOCK_50_I) begin
	if (in_valid) begin
		mem_y_even[wr_ptr] <= in_y_even;
		mem_y_odd[wr_ptr] <= in_y_odd;
		mem_u[wr_ptr] <= in_u;   // Chroma of the even pixel
		mem_v[wr_ptr] <= in_v;
	end
end

always_ff @(posedge CLOCK_50_I or negedge resetn) begin
	if (!resetn) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
		in_credit <= 1'b0;
	end else begin
		if (in_valid) wr_ptr <= next_ptr(wr_ptr);
		if (pop) rd_ptr <= next_ptr(rd_ptr);
		count <= count + yuv_pkg::fifo_cnt_t'(in_valid) - yuv_pkg::fifo_cnt_t'(pop);
		in_credit <= pop;   // Freed slot goes back to the sender
	end
end

assign fifo_empty = (count == '0);
assign head_y_even = mem_y_even[rd_ptr];
assign head_y_odd = mem_y_odd[rd_ptr];
assign head_u = mem_u[rd_ptr];
assign head_v = mem_v[rd_ptr];

// A write into a full buffer means the sender spent a credit it did not hold
assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
	in_valid |-> count != yuv_pkg::fifo_cnt_t'(yuv_pkg::IN_DEPTH))
	else $error("pair_fifo: write while full");

assert property (@(posedge CLOCK_50_I) disable iff (!resetn) pop |-> !fifo_empty)
	else $error("pair_fifo: pop while empty");

endmodule

//--- verilog/chroma_upsampler.sv
//--------------------
// Six-sample chroma window with the 21/52/159 interpolation filter
// One instance per chroma channel, stepped by the row sequencer
//--------------------
`timescale 1ns/1ps

module chroma_upsampler (
	input  logic CLOCK_50_I,
	input  logic resetn,
	input  logic step,
	input  logic load_first,
	input  logic replicate,
	input  yuv_pkg::byte_t sample,
	output yuv_pkg::byte_t even_c,
	output yuv_pkg::byte_t odd_c
);

// win[0] is the oldest sample
// On a producing step it holds indices j-2 .. j+3 of row pair j
yuv_pkg::byte_t win [6];

yuv_pkg::acc_t sum_inner;
yuv_pkg::acc_t sum_middle;
yuv_pkg::acc_t sum_outer;
yuv_pkg::acc_t filt;

always_ff @(posedge CLOCK_50_I or negedge resetn) begin
	if (!resetn) begin
		for (int i = 0; i < 6; i++) begin
			win[i] <= '0;
		end
	end else if (step) begin
		if (load_first) begin
			// Left edge clamp
			for (int i = 0; i < 6; i++) begin
				win[i] <= sample;
			end
		end else begin
			for (int i = 0; i < 5; i++) begin
				win[i] <= win[i+1];
			end
			win[5] <= replicate ? win[5] : sample;   // Right edge repeats newest
		end
	end
end

assign sum_inner = yuv_pkg::acc_t'(win[2]) + yuv_pkg::acc_t'(win[3]);
assign sum_middle = yuv_pkg::acc_t'(win[1]) + yuv_pkg::acc_t'(win[4]);
assign sum_outer = yuv_pkg::acc_t'(win[0]) + yuv_pkg::acc_t'(win[5]);

// Taps sum to 256, so the shift restores the sample scale
assign filt = yuv_pkg::TAP_159 * sum_inner
	- yuv_pkg::TAP_52 * sum_middle
	+ yuv_pkg::TAP_21 * sum_outer
	+ yuv_pkg::FILT_ROUND;

assign even_c = win[2];   // Even pixel keeps its own sample
assign odd_c = yuv_pkg::clip_byte(filt >>> 8);

endmodule

//--- verilog/rgb_converter.sv
//--------------------
// Two-stage fixed-point YUV to RGB conversion for one pixel pair
// Stage one forms the products, stage two sums and clips
//--------------------
`timescale 1ns/1ps

module rgb_converter (
	input  logic CLOCK_50_I,
	input  logic resetn,
	input  logic conv_valid,
	input  yuv_pkg::byte_t y_even,
	input  yuv_pkg::byte_t y_odd,
	input  yuv_pkg::byte_t u_even,
	input  yuv_pkg::byte_t u_odd,
	input  yuv_pkg::byte_t v_even,
	input  yuv_pkg::byte_t v_odd,
	output logic rgb_valid,
	output yuv_pkg::rgb_t rgb_even,
	output yuv_pkg::rgb_t rgb_odd
);

// Index 0 is the even pixel, 1 the odd one
yuv_pkg::byte_t y_in [2];
yuv_pkg::byte_t u_in [2];
yuv_pkg::byte_t v_in [2];

yuv_pkg::acc_t y_prod [2];
yuv_pkg::acc_t rv_prod [2];
yuv_pkg::acc_t gu_prod [2];
yuv_pkg::acc_t gv_prod [2];
yuv_pkg::acc_t bu_prod [2];
yuv_pkg::rgb_t rgb_q [2];

// One bit per register stage, the sequencer step accounts for the rest
logic [yuv_pkg::PIPE_LAT-2:0] vld_pipe;

// Integer part of a 16.16 sum, saturated
function automatic yuv_pkg::byte_t channel(input yuv_pkg::acc_t s);
	return yuv_pkg::clip_byte(s >>> 16);
endfunction

assign y_in[0] = y_even;
assign y_in[1] = y_odd;
assign u_in[0] = u_even;
assign u_in[1] = u_odd;
assign v_in[0] = v_even;
assign v_in[1] = v_odd;

always_ff @(posedge CLOCK_50_I) begin
	if (conv_valid) begin
		for (int p = 0; p < 2; p++) begin
			y_prod[p] <= (yuv_pkg::acc_t'(y_in[p]) - yuv_pkg::Y_OFFSET) * yuv_pkg::K_Y;
			rv_prod[p] <= (yuv_pkg::acc_t'(v_in[p]) - yuv_pkg::C_OFFSET) * yuv_pkg::K_RV;
			gu_prod[p] <= (yuv_pkg::acc_t'(u_in[p]) - yuv_pkg::C_OFFSET) * yuv_pkg::K_GU;
			gv_prod[p] <= (yuv_pkg::acc_t'(v_in[p]) - yuv_pkg::C_OFFSET) * yuv_pkg::K_GV;
			bu_prod[p] <= (yuv_pkg::acc_t'(u_in[p]) - yuv_pkg::C_OFFSET) * yuv_pkg::K_BU;
		end
	end
end

always_ff @(posedge CLOCK_50_I) begin
	if (vld_pipe[0]) begin
		for (int p = 0; p < 2; p++) begin
			rgb_q[p] <= {channel(y_prod[p] + rv_prod[p]),
				channel(y_prod[p] - gu_prod[p] - gv_prod[p]),
				channel(y_prod[p] + bu_prod[p])};
		end
	end
end

always_ff @(posedge CLOCK_50_I or negedge resetn) begin
	if (!resetn) begin
		vld_pipe <= '0;
	end else begin
		vld_pipe <= {vld_pipe[yuv_pkg::PIPE_LAT-3:0], conv_valid};
	end
end

assign rgb_valid = vld_pipe[yuv_pkg::PIPE_LAT-2];
assign rgb_even = rgb_q[0];
assign rgb_odd = rgb_q[1];

endmodule

//--- verilog/row_sequencer.sv
//--------------------
// Per-row fill, run and flush control with the output credit counter
// Also delays luma so it lines up with the chroma window
//--------------------
`timescale 1ns/1ps

module row_sequencer (
	input  logic CLOCK_50_I,
	input  logic resetn,
	input  logic fifo_empty,
	input  yuv_pkg::byte_t head_y_even,
	input  yuv_pkg::byte_t head_y_odd,
	input  logic out_credit,
	output logic pop,
	output logic step,
	output logic load_first,
	output logic replicate,
	output logic conv_valid,
	output yuv_pkg::byte_t y_even,
	output yuv_pkg::byte_t y_odd
);

yuv_pkg::seq_state_e state;
yuv_pkg::pair_idx_t pair_idx;      // Pops in FILL and RUN, steps in FLUSH
yuv_pkg::credit_t credit_cnt;
logic have_credit;
logic produce;
yuv_pkg::byte_t ye_dly [3];
yuv_pkg::byte_t yo_dly [3];

assign have_credit = (credit_cnt != '0);

always_comb begin
	pop = 1'b0;
	replicate = 1'b0;
	case (state)
	yuv_pkg::FILL: pop = !fifo_empty;   // No credit needed, no output
	yuv_pkg::RUN: pop = !fifo_empty && have_credit;
	yuv_pkg::FLUSH: replicate = have_credit;
	default: pop = 1'b0;
	endcase
end

assign step = pop || replicate;
assign produce = step && (state != yuv_pkg::FILL);
assign load_first = pop && (state == yuv_pkg::FILL) && (pair_idx == '0);

always_ff @(posedge CLOCK_50_I or negedge resetn) begin
	if (!resetn) begin
		state <= yuv_pkg::FILL;
		pair_idx <= '0;
		credit_cnt <= '0;
		conv_valid <= 1'b0;
	end else begin
		credit_cnt <= credit_cnt + yuv_pkg::credit_t'(out_credit)
			- yuv_pkg::credit_t'(produce);   // Reserved at issue
		conv_valid <= produce;
		if (step) begin
			pair_idx <= pair_idx + 1'b1;
			case (state)
			yuv_pkg::FILL: if (pair_idx == yuv_pkg::pair_idx_t'(2)) state <= yuv_pkg::RUN;
			yuv_pkg::RUN: begin
				if (pair_idx == yuv_pkg::pair_idx_t'(yuv_pkg::ROW_PAIRS - 1)) begin
					state <= yuv_pkg::FLUSH;
					pair_idx <= '0;
				end
			end
			yuv_pkg::FLUSH: begin
				if (pair_idx == yuv_pkg::pair_idx_t'(2)) begin
					state <= yuv_pkg::FILL;
					pair_idx <= '0;
				end
			end
			default: state <= yuv_pkg::FILL;
			endcase
		end
	end
end

// Three steps of luma delay plus the output register
always_ff @(posedge CLOCK_50_I) begin
	if (step) begin
		ye_dly[0] <= head_y_even;
		ye_dly[1] <= ye_dly[0];
		ye_dly[2] <= ye_dly[1];
		yo_dly[0] <= head_y_odd;
		yo_dly[1] <= yo_dly[0];
		yo_dly[2] <= yo_dly[1];
		y_even <= ye_dly[2];
		y_odd <= yo_dly[2];
	end
end

// The credit source must respect the outstanding limit
assert property (@(posedge CLOCK_50_I) disable iff (!resetn)
	credit_cnt <= yuv_pkg::credit_t'(yuv_pkg::OUT_CREDIT_MAX))
	else $error("row_sequencer: output credits above limit");

endmodule

//--- verilog/yuv_to_rgb_top.sv
//--------------------
// YUV 4:2:2 pair stream in, RGB pair stream out
// Both sides use credit flow control
//--------------------
`timescale 1ns/1ps

module yuv_to_rgb_top (
	input  logic CLOCK_50_I,
	input  logic resetn,
	input  logic in_valid,
	input  yuv_pkg::byte_t in_y_even,
	input  yuv_pkg::byte_t in_y_odd,
	input  yuv_pkg::byte_t in_u,
	input  yuv_pkg::byte_t in_v,
	output logic in_credit,
	input  logic out_credit,
	output logic rgb_valid,
	output yuv_pkg::rgb_t rgb_even,
	output yuv_pkg::rgb_t rgb_odd
);

logic fifo_empty;
logic pop;
yuv_pkg::byte_t head_y_even, head_y_odd, head_u, head_v;
logic step, load_first, replicate;
yuv_pkg::byte_t u_even, u_odd, v_even, v_odd;
logic conv_valid;
yuv_pkg::byte_t y_even, y_odd;

pair_fifo input_fifo (
	.CLOCK_50_I(CLOCK_50_I),
	.resetn(resetn),
	.in_valid(in_valid),
	.in_y_even(in_y_even),
	.in_y_odd(in_y_odd),
	.in_u(in_u),
	.in_v(in_v),
	.pop(pop),
	.fifo_empty(fifo_empty),
	.head_y_even(head_y_even),
	.head_y_odd(head_y_odd),
	.head_u(head_u),
	.head_v(head_v),
	.in_credit(in_credit)
);

row_sequencer sequencer (
	.CLOCK_50_I(CLOCK_50_I),
	.resetn(resetn),
	.fifo_empty(fifo_empty),
	.head_y_even(head_y_even),
	.head_y_odd(head_y_odd),
	.out_credit(out_credit),
	.pop(pop),
	.step(step),
	.load_first(load_first),
	.replicate(replicate),
	.conv_valid(conv_valid),
	.y_even(y_even),
	.y_odd(y_odd)
);

// U and V share the same stepping
chroma_upsampler u_upsampler (
	.CLOCK_50_I(CLOCK_50_I), .resetn(resetn),
	.step(step), .load_first(load_first), .replicate(replicate),
	.sample(head_u), .even_c(u_even), .odd_c(u_odd)
);

chroma_upsampler v_upsampler (
	.CLOCK_50_I(CLOCK_50_I), .resetn(resetn),
	.step(step), .load_first(load_first), .replicate(replicate),
	.sample(head_v), .even_c(v_even), .odd_c(v_odd)
);

rgb_converter converter (
	.CLOCK_50_I(CLOCK_50_I),
	.resetn(resetn),
	.conv_valid(conv_valid),
	.y_even(y_even),
	.y_odd(y_odd),
	.u_even(u_even),
	.u_odd(u_odd),
	.v_even(v_even),
	.v_odd(v_odd),
	.rgb_valid(rgb_valid),
	.rgb_even(rgb_even),
	.rgb_odd(rgb_odd)
);

endmodule

//--- include/tb_reference.svh
//--------------------
// Reference models for the YUV to RGB testbench
// Included inside the testbench module for stimulus and expected values
//--------------------
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

// One Galois LFSR shift
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// Takes nbits fresh bits, LSB first, one shift per bit
function automatic int lfsr_take(ref logic [31:0] s, input int nbits);
	int v;
	v = 0;
	for (int i = 0; i < nbits; i++) begin
		s = lfsr_step(s);
		v = v | (int'(s[0]) << i);
	end
	return v;
endfunction

function automatic int ref_clip(input int v);
	if (v < 0) return 0;
	if (v > 255) return 255;
	return v;
endfunction

// Odd-pixel chroma of pair j, samples clamped at both row ends
function automatic int ref_odd_chroma(input int c [yuv_pkg::ROW_PAIRS], input int j);
	int s [6];
	int idx;
	for (int k = 0; k < 6; k++) begin
		idx = j - 2 + k;
		if (idx < 0) idx = 0;
		if (idx > yuv_pkg::ROW_PAIRS - 1) idx = yuv_pkg::ROW_PAIRS - 1;
		s[k] = c[idx];
	end
	return ref_clip((yuv_pkg::TAP_21 * (s[0] + s[5]) - yuv_pkg::TAP_52 * (s[1] + s[4])
		+ yuv_pkg::TAP_159 * (s[2] + s[3]) + yuv_pkg::FILT_ROUND) >>> 8);
endfunction

function automatic logic [23:0] ref_rgb(input int y, input int u, input int v);
	int yp;
	int r;
	int g;
	int b;
	yp = (y - yuv_pkg::Y_OFFSET) * yuv_pkg::K_Y;
	r = yp + yuv_pkg::K_RV * (v - yuv_pkg::C_OFFSET);
	g = yp - yuv_pkg::K_GU * (u - yuv_pkg::C_OFFSET) - yuv_pkg::K_GV * (v - yuv_pkg::C_OFFSET);
	b = yp + yuv_pkg::K_BU * (u - yuv_pkg::C_OFFSET);
	return {8'(ref_clip(r >>> 16)), 8'(ref_clip(g >>> 16)), 8'(ref_clip(b >>> 16))};
endfunction

`endif

//--- testbench/tb_yuv_to_rgb.sv
//--------------------
// Testbench for the YUV 4:2:2 to RGB top level
// Sends random pairs and output credits and checks each RGB pair against the reference model
//--------------------
`timescale 1ns/1ps

module tb_yuv_to_rgb;

`include "tb_reference.svh"

localparam int ROWS = 6;
localparam int TOTAL = ROWS * yuv_pkg::ROW_PAIRS;
localparam int HOLD_AT = 3 * yuv_pkg::ROW_PAIRS + 2;   // Pair whose send pauses the grants
localparam int HOLD_CYCLES = 60;
localparam int RUN_TIMEOUT = 5000;

logic CLOCK_50_I = 1'b0;
logic resetn;
logic in_valid;
yuv_pkg::byte_t in_y_even, in_y_odd, in_u, in_v;
logic in_credit;
logic out_credit;
logic rgb_valid;
yuv_pkg::rgb_t rgb_even, rgb_odd;

int y_e [ROWS][yuv_pkg::ROW_PAIRS];
int y_o [ROWS][yuv_pkg::ROW_PAIRS];
int u_s [ROWS][yuv_pkg::ROW_PAIRS];
int v_s [ROWS][yuv_pkg::ROW_PAIRS];
logic [47:0] expected [$];   // {even, odd} per output pair
logic [31:0] seed = 32'h7d42c164;

int sent_seen = 0;
int credits_back = 0;
int grants_seen = 0;
int rx_count = 0;

yuv_to_rgb_top UUT (
	.CLOCK_50_I(CLOCK_50_I),
	.resetn(resetn),
	.in_valid(in_valid),
	.in_y_even(in_y_even),
	.in_y_odd(in_y_odd),
	.in_u(in_u),
	.in_v(in_v),
	.in_credit(in_credit),
	.out_credit(out_credit),
	.rgb_valid(rgb_valid),
	.rgb_even(rgb_even),
	.rgb_odd(rgb_odd)
);

always #5 CLOCK_50_I = ~CLOCK_50_I;

task automatic stop_run();
	$display("TESTBENCH FAILED");
	$fatal(1, "Simulation stopped on the first error");
endtask

task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
	if (got !== exp) begin
		$display("FAIL at %0t: %s, got %0h expected %0h", $time, what, got, exp);
		stop_run();
	end
endtask

// Random rows with two clipping corners, then the expected output pairs
task automatic build_rows();
	logic [23:0] even_px;
	logic [23:0] odd_px;
	for (int r = 0; r < ROWS; r++) begin
		for (int j = 0; j < yuv_pkg::ROW_PAIRS; j++) begin
			y_e[r][j] = lfsr_take(seed, 8);
			y_o[r][j] = lfsr_take(seed, 8);
			u_s[r][j] = lfsr_take(seed, 8);
			v_s[r][j] = lfsr_take(seed, 8);
		end
	end
	y_e[0][0] = 255;   // Red saturates
	v_s[0][0] = 255;
	y_e[1][3] = 0;     // Blue bottoms out
	u_s[1][3] = 0;
	for (int r = 0; r < ROWS; r++) begin
		for (int j = 0; j < yuv_pkg::ROW_PAIRS; j++) begin
			even_px = ref_rgb(y_e[r][j], u_s[r][j], v_s[r][j]);
			odd_px = ref_rgb(y_o[r][j], ref_odd_chroma(u_s[r], j), ref_odd_chroma(v_s[r], j));
			expected.push_back({even_px, odd_px});
		end
	end
endtask

// Monitor sees the same edge values as the DUT
always @(posedge CLOCK_50_I) begin
	logic [47:0] exp_pair;
	if (resetn) begin
		if (in_valid) sent_seen++;
		if (in_credit) credits_back++;
		if (out_credit) grants_seen++;
		compare(32'(credits_back <= sent_seen), 32'd1, "in_credit only for pairs sent");
		if (rgb_valid) begin
			if (expected.size() == 0) begin
				$display("An output pair arrived after the last expected pair");
				stop_run();
			end else begin
				exp_pair = expected.pop_front();
				compare(32'(rx_count < grants_seen), 32'd1, "output pair without a granted credit");
				compare(32'(rgb_even), 32'(exp_pair[47:24]), $sformatf("even pixel %0d", rx_count));
				compare(32'(rgb_odd), 32'(exp_pair[23:0]), $sformatf("odd pixel %0d", rx_count));
				if (rx_count == 0) compare(32'(rgb_even[23:16]), 32'd255, "red clip high");
				if (rx_count == yuv_pkg::ROW_PAIRS + 3) compare(32'(rgb_even[7:0]), 32'd0, "blue clip low");
				rx_count++;
			end
		end
	end
end

initial begin
	int in_cred;
	int next_pair;
	int granted;
	int got;
	int hold_cnt;
	int cycles;
	int r;
	int j;
	resetn = 1'b0;
	in_valid = 1'b0;
	in_y_even = '0;
	in_y_odd = '0;
	in_u = '0;
	in_v = '0;
	out_credit = 1'b0;
	build_rows();
	repeat (16) @(posedge CLOCK_50_I);
	resetn <= 1'b1;
	// Nothing comes back before pairs and credits go in
	repeat (8) begin
		@(posedge CLOCK_50_I);
		compare(32'(in_credit), 32'd0, "in_credit idle after reset");
		compare(32'(rgb_valid), 32'd0, "rgb_valid idle after reset");
	end
	in_cred = yuv_pkg::IN_DEPTH;
	next_pair = 0;
	granted = 0;
	got = 0;
	hold_cnt = 0;
	cycles = 0;
	while (got < TOTAL) begin
		@(posedge CLOCK_50_I);
		cycles++;
		if (cycles > RUN_TIMEOUT) begin
			$display("Timed out waiting for output pairs, %0d of %0d received", got, TOTAL);
			stop_run();
		end
		if (in_credit) in_cred++;
		if (rgb_valid) got++;
		in_valid <= 1'b0;
		out_credit <= 1'b0;
		if (hold_cnt > 0) begin
			hold_cnt--;
			if (hold_cnt == 0) begin
				compare(32'(got), 32'(granted), "output stops with credits withheld");
				compare(32'(in_cred), 32'd0, "sender out of input credits during hold");
			end
		end else if (granted - got < yuv_pkg::OUT_CREDIT_MAX && lfsr_take(seed, 1) != 0) begin
			out_credit <= 1'b1;
			granted++;
		end
		if (next_pair < TOTAL && in_cred > 0 && lfsr_take(seed, 2) != 0) begin
			r = next_pair / yuv_pkg::ROW_PAIRS;
			j = next_pair % yuv_pkg::ROW_PAIRS;
			in_valid <= 1'b1;
			in_y_even <= 8'(y_e[r][j]);
			in_y_odd <= 8'(y_o[r][j]);
			in_u <= 8'(u_s[r][j]);
			in_v <= 8'(v_s[r][j]);
			in_cred--;
			if (next_pair == HOLD_AT) hold_cnt = HOLD_CYCLES;
			next_pair++;
		end
	end
	out_credit <= 1'b0;
	repeat (20) @(posedge CLOCK_50_I);   // Extra pairs in the quiet tail trip the monitor
	compare(32'(credits_back), 32'(TOTAL), "in_credit pulse total");
	$display("TESTBENCH PASSED");
	$finish;
end

endmodule

//--- sim.f
+incdir+include
verilog/yuv_pkg.sv
verilog/pair_fifo.sv
verilog/chroma_upsampler.sv
verilog/rgb_converter.sv
verilog/row_sequencer.sv
verilog/yuv_to_rgb_top.sv
testbench/tb_yuv_to_rgb.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_yuv_to_rgb -o sim_tb \
	> build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log && echo "Simulation passed" || { echo "No result in log"; exit 1; }
